//--- Makefile
# Verilator flow for the external slave subsystem
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ext_subsys_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- logic/ext_pkg.sv
// External slave package
// Memory geometry and bus field types shared by the FIFO, memory and top level

package ext_pkg;

  // Memory geometry
  localparam int unsigned NUM_WORDS = 128;
  localparam int unsigned DATA_WIDTH = 32;

  // Byte address on the bus
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // One enable per data byte
  typedef logic [DATA_WIDTH/8-1:0] be_t;

  // Word index, address bits 8 down to 2
  typedef logic [$clog2(NUM_WORDS)-1:0] word_idx_t;

  // Slow memory FSM
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_BUSY,
    MEM_RESP
  } mem_state_e;

endpackage

//--- logic/ext_subsys.sv
// External slave subsystem
// Request FIFO in front of a slow memory, plus power switch acknowledge emulation

`timescale 1ns/1ps

module ext_subsys
  import ext_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH         = 4,
  parameter int unsigned MEM_LATENCY        = 3,
  parameter int unsigned SWITCH_ACK_LATENCY = 15,
  parameter int unsigned NUM_DOMAINS        = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // OBI-style slave port
  input  logic                   req_i,
  input  logic                   we_i,
  input  be_t                    be_i,
  input  addr_t                  addr_i,
  input  data_t                  wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output data_t                  rdata_o,

  // Power switch request and acknowledge
  input  logic [NUM_DOMAINS-1:0] switch_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_o
);

  mem_req_if mem_req ();

  // FIFO adds latency in front of the memory
  obi_req_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) obi_req_fifo_i (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .be_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .mem_o   (mem_req)
  );

  slow_memory #(
    .MEM_LATENCY(MEM_LATENCY)
  ) slow_memory_i (
    .clk_i,
    .rst_n_i,
    .mem_i   (mem_req),
    .rvalid_o,
    .rdata_o
  );

  power_switch_ack #(
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .NUM_DOMAINS       (NUM_DOMAINS)
  ) power_switch_ack_i (
    .clk_i,
    .rst_n_i,
    .switch_i,
    .switch_ack_o
  );

endmodule

//--- logic/mem_req_if.sv
// Request channel between the request FIFO and the slow memory
// Head entry of the FIFO moves on req and gnt both high

`timescale 1ns/1ps

interface mem_req_if
  import ext_pkg::*;
();

  logic  req;
  logic  gnt;
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;

  modport producer(
    output req,
    output we,
    output be,
    output addr,
    output wdata,
    input  gnt
  );

  modport consumer(
    input  req,
    input  we,
    input  be,
    input  addr,
    input  wdata,
    output gnt
  );

endinterface

//--- logic/obi_req_fifo.sv
// OBI request FIFO
// Grants bus requests while there is room and presents the oldest entry to the memory

`timescale 1ns/1ps

module obi_req_fifo
  import ext_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  be_t               be_i,
  input  addr_t             addr_i,
  input  data_t             wdata_i,
  output logic              gnt_o,
  mem_req_if.producer       mem_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // Entry storage
  logic  we_q    [FIFO_DEPTH];
  be_t   be_q    [FIFO_DEPTH];
  addr_t addr_q  [FIFO_DEPTH];
  data_t wdata_q [FIFO_DEPTH];

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // Grant straight from the master request
  assign gnt_o = req_i & ~full;
  assign push  = gnt_o;
  assign pop   = mem_o.req & mem_o.gnt;

  // Head entry towards the memory
  assign mem_o.req   = ~empty;
  assign mem_o.we    = we_q[rd_ptr_q];
  assign mem_o.be    = be_q[rd_ptr_q];
  assign mem_o.addr  = addr_q[rd_ptr_q];
  assign mem_o.wdata = wdata_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_q[wr_ptr_q]    <= we_i;
      be_q[wr_ptr_q]    <= be_i;
      addr_q[wr_ptr_q]  <= addr_i;
      wdata_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

//--- logic/power_switch_ack.sv
// Power switch cell emulation
// Each domain acknowledge follows its switch request SWITCH_ACK_LATENCY cycles later

`timescale 1ns/1ps

module power_switch_ack #(
  parameter int unsigned SWITCH_ACK_LATENCY = 15,
  parameter int unsigned NUM_DOMAINS        = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_o
);

  // One stage per cycle of delay
  logic [NUM_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

//--- logic/slow_memory.sv
// Slow word memory
// Serves one request at a time and answers MEM_LATENCY cycles after the grant

`timescale 1ns/1ps

module slow_memory
  import ext_pkg::*;
#(
  parameter int unsigned MEM_LATENCY = 3
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  mem_req_if.consumer mem_i,
  output logic        rvalid_o,
  output data_t       rdata_o
);

  localparam int unsigned CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  mem_state_e       state_q;
  mem_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             accept;
  logic             delay_done;

  // Latched request
  logic      we_q;
  be_t       be_q;
  word_idx_t idx_q;
  data_t     wdata_q;

  data_t mem_q [NUM_WORDS];

  // Only free in idle, and never without a request
  assign mem_i.gnt  = (state_q == MEM_IDLE) & mem_i.req;
  assign accept     = mem_i.req & mem_i.gnt;
  assign delay_done = (cnt_q == CNT_W'(MEM_LATENCY - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      MEM_IDLE: if (accept) state_d = MEM_BUSY;
      MEM_BUSY: if (delay_done) state_d = MEM_RESP;
      MEM_RESP: state_d = MEM_IDLE;
      default:  state_d = MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= (state_q == MEM_BUSY) ? cnt_q + 1'b1 : '0;
    end
  end

  // Upper address bits are dropped, so addresses alias
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= mem_i.we;
      be_q    <= mem_i.be;
      idx_q   <= mem_i.addr[$bits(word_idx_t)+1:2];
      wdata_q <= mem_i.wdata;
    end
  end

  // Byte merge on write
  always_ff @(posedge clk_i) begin
    if (state_q == MEM_RESP && we_q) begin
      for (int b = 0; b < DATA_WIDTH / 8; b++) begin
        if (be_q[b]) begin
          mem_q[idx_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
        end
      end
    end
  end

  assign rvalid_o = (state_q == MEM_RESP);
  assign rdata_o  = mem_q[idx_q];

endmodule

//--- sim/ext_subsys_checker.sv
// Response checker for the external slave subsystem
// Models the word memory and the switch delay lines, compares DUT outputs

`timescale 1ns/1ps

module ext_subsys_checker
  import ext_pkg::*;
#(
  parameter int unsigned NUM_DOMAINS = 1
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_i,
  input logic                   we_i,
  input be_t                    be_i,
  input addr_t                  addr_i,
  input data_t                  wdata_i,
  input logic                   gnt_i,
  input logic                   rvalid_i,
  input data_t                  rdata_i,
  input logic [NUM_DOMAINS-1:0] switch_i,
  input logic [NUM_DOMAINS-1:0] switch_ack_i,
  input int unsigned            ack_latency_i
);

  data_t                  model_mem [NUM_WORDS];
  be_t                    known_be [NUM_WORDS];
  data_t                  exp_data_q [$];
  data_t                  exp_mask_q [$];
  logic [NUM_DOMAINS-1:0] switch_hist [$];

  int error_count;
  int grant_count;
  int resp_count;

  // Reference for a write, enabled bytes replace the old ones
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic data_t byte_mask(be_t be);
    data_t mask;
    for (int b = 0; b < DATA_WIDTH / 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  initial begin
    error_count = 0;
    grant_count = 0;
    resp_count  = 0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      known_be[i] = '0;
    end
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    data_t                  exp_data;
    data_t                  exp_mask;
    logic [NUM_DOMAINS-1:0] exp_ack;
    if (!rst_n_i) begin
      exp_data_q.delete();
      exp_mask_q.delete();
      switch_hist.delete();
    end else begin
      if (rvalid_i) begin
        resp_count++;
        if (exp_data_q.size() == 0) begin
          error_count++;
          $display("rvalid_o pulse at %0t with no request outstanding", $time);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_mask = exp_mask_q.pop_front();
          if ((rdata_i & exp_mask) !== (exp_data & exp_mask)) begin
            error_count++;
            $display("Error: %0t rdata_o expected %h got %h", $time, exp_data & exp_mask,
                     rdata_i & exp_mask);
          end
        end
      end
      // Model follows grant order, so queued read data is final
      if (req_i && gnt_i) begin
        grant_count++;
        if (we_i) begin
          model_mem[addr_i[8:2]] = merge_bytes(model_mem[addr_i[8:2]], wdata_i, be_i);
          known_be[addr_i[8:2]]  = known_be[addr_i[8:2]] | be_i;
          exp_data_q.push_back('0);
          exp_mask_q.push_back('0);
        end else begin
          exp_data_q.push_back(model_mem[addr_i[8:2]]);
          exp_mask_q.push_back(byte_mask(known_be[addr_i[8:2]]));
        end
      end
      // Acks stay low until the delay line has filled
      if (switch_hist.size() == ack_latency_i) begin
        exp_ack = switch_hist.pop_front();
      end else begin
        exp_ack = '0;
      end
      if (switch_ack_i !== exp_ack) begin
        error_count++;
        $display("Error: %0t switch_ack_o expected %b got %b", $time, exp_ack, switch_ack_i);
      end
      switch_hist.push_back(switch_i);
    end
  end

endmodule

//--- sim/ext_subsys_sva.sv
// Port assertions for the external slave subsystem
// Grant rule, known outputs and exact switch acknowledge delay

`timescale 1ns/1ps

module ext_subsys_sva #(
  parameter int unsigned SWITCH_ACK_LATENCY = 1,
  parameter int unsigned NUM_DOMAINS        = 1
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_i,
  input logic                   gnt_i,
  input logic                   rvalid_i,
  input logic [NUM_DOMAINS-1:0] switch_i,
  input logic [NUM_DOMAINS-1:0] switch_ack_i
);

  // Edges since reset, saturating once the delay history is complete
  int unsigned cycles_q;

  int unsigned error_count = 0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycles_q <= 0;
    end else if (cycles_q < SWITCH_ACK_LATENCY) begin
      cycles_q <= cycles_q + 1;
    end
  end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_i |-> req_i)
    else begin
      error_count++;
      $error("gnt_o high without req_i");
    end

  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({rvalid_i, switch_ack_i}))
    else begin
      error_count++;
      $error("unknown value on rvalid_o or switch_ack_o");
    end

  ack_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cycles_q >= SWITCH_ACK_LATENCY) |-> (switch_ack_i == $past(switch_i, SWITCH_ACK_LATENCY)))
    else begin
      error_count++;
      $error("switch_ack_o does not match delayed switch_i");
    end

endmodule

//--- sim/ext_subsys_tb.sv
// Testbench for the external slave subsystem
// Drives bus and switch stimulus, prints one line per test and the totals

`timescale 1ns/1ps

module ext_subsys_tb
  import ext_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk_i;
  logic       rst_n_i;
  logic       req_i;
  logic       we_i;
  be_t        be_i;
  addr_t      addr_i;
  data_t      wdata_i;
  logic       gnt_o;
  logic       rvalid_o;
  data_t      rdata_o;
  // Four domains, as the top level defaults to
  logic [3:0] switch_i;
  logic [3:0] switch_ack_o;

  int seed;
  int local_errors;
  int stall_cycles;
  int pass_count;
  int fail_count;

  ext_subsys dut0 (.*);

  ext_subsys_checker #(
    .NUM_DOMAINS($bits(switch_i))
  ) chk0 (
    .clk_i, .rst_n_i, .req_i, .we_i, .be_i, .addr_i, .wdata_i,
    .gnt_i(gnt_o), .rvalid_i(rvalid_o), .rdata_i(rdata_o),
    .switch_i, .switch_ack_i(switch_ack_o),
    .ack_latency_i(dut0.SWITCH_ACK_LATENCY)
  );

  bind ext_subsys ext_subsys_sva #(
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .NUM_DOMAINS       (NUM_DOMAINS)
  ) sva0 (
    .clk_i, .rst_n_i, .req_i, .gnt_i(gnt_o), .rvalid_i(rvalid_o),
    .switch_i, .switch_ack_i(switch_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic int total_errors();
    return local_errors + chk0.error_count + dut0.sva0.error_count;
  endfunction

  // Called on a falling edge, returns on the falling edge after the grant
  task automatic send_request(input logic we, input be_t be, input addr_t addr,
                              input data_t wdata);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    we_i    = we;
    be_i    = be;
    addr_i  = addr;
    wdata_i = wdata;
    @(posedge clk_i);
    while (!gnt_o && waited < TIMEOUT_CYCLES) begin
      stall_cycles++;
      waited++;
      @(posedge clk_i);
    end
    if (!gnt_o) begin
      local_errors++;
      $display("request to address %h was never granted", addr);
    end
    @(negedge clk_i);
  endtask

  task automatic random_access();
    logic [31:0] r;
    r = $random(seed);
    send_request(r[0], r[7:4], {r[31:29], 21'h0, 2'b00, r[11:8], 2'b00}, $random(seed));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (chk0.resp_count != chk0.grant_count && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (chk0.resp_count != chk0.grant_count) begin
      local_errors++;
      $display("responses still missing after %0d cycles", TIMEOUT_CYCLES);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (total_errors() == errs_before) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: FAILED with %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial begin
    int errs;
    int grants;
    int waited;
    seed         = 32'h11d5;
    local_errors = 0;
    stall_cycles = 0;
    pass_count   = 0;
    fail_count   = 0;
    rst_n_i      = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    be_i         = '0;
    addr_i       = '0;
    wdata_i      = '0;
    switch_i     = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    errs = total_errors();
    if (gnt_o !== 1'b0 || rvalid_o !== 1'b0 || switch_ack_o !== 4'b0) begin
      local_errors++;
      $display("Error: %0t gnt_o/rvalid_o/switch_ack_o expected 0/0/0000 got %b/%b/%b",
               $time, gnt_o, rvalid_o, switch_ack_o);
    end
    report_test("reset state", errs);

    errs = total_errors();
    send_request(1'b1, 4'hf, 32'h0000_0040, 32'ha5c3_0f1e);
    send_request(1'b0, 4'hf, 32'h0000_0040, '0);
    req_i = 1'b0;
    wait_drained();
    report_test("write then read", errs);

    // 0x284 and 0x8000_0084 alias word 33
    errs = total_errors();
    send_request(1'b1, 4'hf, 32'h0000_0084, 32'h1122_3344);
    send_request(1'b1, 4'b0101, 32'h0000_0084, 32'haabb_ccdd);
    send_request(1'b1, 4'b1000, 32'h0000_0284, 32'h99ee_ee00);
    send_request(1'b0, 4'hf, 32'h8000_0084, '0);
    req_i = 1'b0;
    wait_drained();
    report_test("byte merge and alias", errs);

    errs         = total_errors();
    grants       = chk0.grant_count;
    stall_cycles = 0;
    for (int i = 0; i < 6; i++) begin
      send_request(1'b1, 4'hf, 32'h100 + 4 * i, 32'hc0de_0000 + i);
    end
    for (int i = 0; i < 6; i++) begin
      send_request(1'b0, 4'hf, 32'h100 + 4 * i, '0);
    end
    req_i = 1'b0;
    wait_drained();
    if (stall_cycles == 0) begin
      local_errors++;
      $display("gnt_o never dropped during the back-to-back burst");
    end
    if (chk0.grant_count - grants != 12) begin
      local_errors++;
      $display("burst of 12 requests got %0d grants", chk0.grant_count - grants);
    end
    report_test("fifo back-pressure", errs);

    errs = total_errors();
    repeat (200) random_access();
    req_i = 1'b0;
    wait_drained();
    report_test("random traffic", errs);

    errs = total_errors();
    fork
      begin
        repeat (40) begin
          switch_i = switch_i ^ 4'($random(seed));
          repeat (($random(seed) & 3) + 1) @(negedge clk_i);
        end
      end
      begin
        for (int i = 0; i < 4; i++) begin
          send_request(1'b1, 4'hf, 32'h0a0 + 4 * i, 32'h5a5a_0000 + i);
        end
        for (int i = 0; i < 4; i++) begin
          send_request(1'b0, 4'hf, 32'h0a0 + 4 * i, '0);
        end
        req_i = 1'b0;
      end
    join
    waited = 0;
    while (switch_ack_o !== switch_i && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (switch_ack_o !== switch_i) begin
      local_errors++;
      $display("switch_ack_o never settled to the final switch_i value");
    end
    wait_drained();
    report_test("switch acknowledge", errs);

    $display("summary: %0d ok, %0d failed, %0d errors", pass_count, fail_count, total_errors());
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/ext_pkg.sv
logic/mem_req_if.sv
logic/obi_req_fifo.sv
logic/slow_memory.sv
logic/power_switch_ack.sv
logic/ext_subsys.sv
sim/ext_subsys_sva.sv
sim/ext_subsys_checker.sv
sim/ext_subsys_tb.sv
